// ==== common/game_pkg.sv ====
`default_nettype none

package game_pkg;

    // Object codes coming from the game logic, 5 to 7 are drawn as blank
    typedef enum logic [2:0] {
        obj_blank  = 3'd0,
        obj_head   = 3'd1,
        obj_body   = 3'd2,
        obj_apple  = 3'd3,
        obj_border = 3'd4
    } obj_code_t;

    typedef struct packed {
        obj_code_t  obj;
        logic [3:0] x;                               // Grid column
        logic [3:0] y;                               // Grid row
    } tile_req_t;

    typedef logic [15:0] rgb565_t;

    // ########################################################################
    // Palette
    // ########################################################################

    localparam rgb565_t color_background = 16'h1408;
    localparam rgb565_t color_head       = 16'h901E;
    localparam rgb565_t color_apple      = 16'h00F8;
    localparam rgb565_t color_border     = 16'h0000;

    // Rainbow register for body tiles
    // Feedback is the XOR of bits 15, 13, 12 and 10, shifted in at bit 0
    localparam rgb565_t rainbow_seed = 16'hACE1;
    localparam rgb565_t rainbow_taps = 16'hB400;

endpackage

`default_nettype wire

// ==== common/lcd_cmd_pkg.sv ====
`default_nettype none

package lcd_cmd_pkg;

    // ########################################################################
    // Display controller opcodes
    // ########################################################################

    typedef enum logic [7:0] {
        cmd_swreset   = 8'h01,
        cmd_sleep_out = 8'h11,
        cmd_disp_off  = 8'h28,
        cmd_disp_on   = 8'h29,
        cmd_caset     = 8'h2A,
        cmd_paset     = 8'h2B,
        cmd_ramwr     = 8'h2C,
        cmd_colmod    = 8'h3A
    } lcd_cmd_t;

    localparam logic [7:0] colmod_rgb565 = 8'h55;    // Pixel format byte for 16-bit colour

    // One byte on the parallel bus
    typedef struct packed {
        logic       wr;                              // Write strobe, one per byte
        logic       dcx;                             // Low for command, high for data
        logic [7:0] data;
    } lcd_bus_t;

    // ########################################################################
    // Sequencer
    // ########################################################################

    typedef enum logic [2:0] {
        ph_idle,
        ph_init_cmd,
        ph_init_wait,
        ph_window,
        ph_pixels,
        ph_done
    } seq_phase_t;

    typedef enum logic [1:0] {
        tk_wait,
        tk_clear,
        tk_tile
    } timer_kind_t;

    // Step numbers that the FSM and the byte generator agree on
    localparam logic [4:0] init_step_swreset   = 5'd0;   // Followed by the first pause
    localparam logic [4:0] init_step_sleep_out = 5'd4;   // Followed by the second pause
    localparam logic [4:0] init_step_last      = 5'd5;   // Display on
    localparam logic [4:0] win_step_ramwr      = 5'd10;  // Memory write, pixels follow

endpackage

`default_nettype wire

// ==== files.f ====
common/lcd_cmd_pkg.sv
common/game_pkg.sv
lcd_ctrl/lcd_seq_fsm.sv
lcd_ctrl/lcd_timer.sv
lcd_ctrl/lcd_byte_gen.sv
logic/tile_color.sv
logic/tile_painter_top.sv
testbench/tb_tile_painter.sv

// ==== lcd_ctrl/lcd_byte_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcd_byte_gen
    import lcd_cmd_pkg::*;
    import game_pkg::*;
#(
    parameter int tile_px  = 20,
    parameter int screen_w = 240,
    parameter int screen_h = 320
) (
    input  logic       clk,
    input  logic       nrst,
    input  seq_phase_t phase,
    input  logic [4:0] step,
    input  logic       hi_byte,
    input  logic       clear,
    input  tile_req_t  tile,
    input  rgb565_t    color,
    output lcd_bus_t   lcd
);

    logic [15:0] col_start;
    logic [15:0] col_end;
    logic [15:0] page_start;
    logic [15:0] page_end;
    lcd_bus_t    lcd_n;

    // ########################################################################
    // Window coordinates
    // ########################################################################

    always_comb begin
        if (clear) begin
            col_start  = '0;
            col_end    = 16'(screen_w - 1);
            page_start = '0;
            page_end   = 16'(screen_h - 1);
        end else begin
            col_start  = 16'(tile.x) * 16'(tile_px);
            col_end    = col_start + 16'(tile_px - 1);
            page_start = 16'(tile.y) * 16'(tile_px);
            page_end   = page_start + 16'(tile_px - 1);
        end
    end

    // ########################################################################
    // Byte select
    // ########################################################################

    always_comb begin
        lcd_n = '0;                                  // Idle, pauses and done keep wr low
        case (phase)
            ph_init_cmd: begin
                lcd_n.wr  = 1'b1;
                lcd_n.dcx = 1'b0;
                case (step)
                    init_step_swreset:   lcd_n.data = cmd_swreset;
                    5'd1:                lcd_n.data = cmd_disp_off;
                    5'd2:                lcd_n.data = cmd_colmod;
                    5'd3: begin
                        lcd_n.data = colmod_rgb565;  // Only data byte of the init list
                        lcd_n.dcx  = 1'b1;
                    end
                    init_step_sleep_out: lcd_n.data = cmd_sleep_out;
                    default:             lcd_n.data = cmd_disp_on;
                endcase
            end

            ph_window: begin
                lcd_n.wr  = 1'b1;
                lcd_n.dcx = 1'b1;
                case (step)
                    5'd0: begin
                        lcd_n.data = cmd_caset;
                        lcd_n.dcx  = 1'b0;
                    end
                    5'd1: lcd_n.data = col_start[15:8];
                    5'd2: lcd_n.data = col_start[7:0];
                    5'd3: lcd_n.data = col_end[15:8];
                    5'd4: lcd_n.data = col_end[7:0];
                    5'd5: begin
                        lcd_n.data = cmd_paset;
                        lcd_n.dcx  = 1'b0;
                    end
                    5'd6: lcd_n.data = page_start[15:8];
                    5'd7: lcd_n.data = page_start[7:0];
                    5'd8: lcd_n.data = page_end[15:8];
                    5'd9: lcd_n.data = page_end[7:0];
                    default: begin
                        lcd_n.data = cmd_ramwr;
                        lcd_n.dcx  = 1'b0;
                    end
                endcase
            end

            ph_pixels: begin
                lcd_n.wr   = 1'b1;
                lcd_n.dcx  = 1'b1;
                lcd_n.data = hi_byte ? color[15:8] : color[7:0];
            end

            default: begin
                lcd_n = '0;
            end
        endcase
    end

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            lcd <= '0;
        end else begin
            lcd <= lcd_n;
        end
    end

endmodule

`default_nettype wire

// ==== lcd_ctrl/lcd_seq_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcd_seq_fsm
    import lcd_cmd_pkg::*;
(
    input  logic        clk,
    input  logic        nrst,
    input  logic        start_init,
    input  logic        start_tile,
    input  logic        timer_last,
    output logic        accept,
    output seq_phase_t  phase,
    output logic [4:0]  step,
    output logic        hi_byte,
    output logic        timer_load,
    output timer_kind_t timer_kind,
    output logic        timer_tick,
    output logic        pixel_advance,
    output logic        fill_tile,
    output logic        busy,
    output logic        done
);

    seq_phase_t phase_n;
    logic [4:0] step_n;
    logic       hi_n;
    logic       in_tile;                             // Set for a tile draw, clear for init

    assign busy      = (phase != ph_idle) || done;   // Covers the done cycle too
    assign accept    = (start_init || start_tile) && !busy;
    assign fill_tile = in_tile && (phase == ph_pixels);

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            phase   <= ph_idle;
            step    <= '0;
            hi_byte <= 1'b0;
            in_tile <= 1'b0;
            done    <= 1'b0;
        end else begin
            phase   <= phase_n;
            step    <= step_n;
            hi_byte <= hi_n;
            done    <= (phase == ph_done);           // Last byte is on the bus during ph_done
            if (accept) begin
                in_tile <= !start_init;              // Init wins over a tile start
            end
        end
    end

    // ########################################################################
    // Next state
    // ########################################################################

    always_comb begin
        phase_n       = phase;
        step_n        = step;
        hi_n          = hi_byte;
        timer_load    = 1'b0;
        timer_kind    = tk_wait;
        timer_tick    = 1'b0;
        pixel_advance = 1'b0;

        case (phase)
            ph_idle: begin
                if (accept) begin
                    phase_n = start_init ? ph_init_cmd : ph_window;
                    step_n  = '0;
                    hi_n    = 1'b0;
                end
            end

            ph_init_cmd: begin
                if (step == init_step_swreset || step == init_step_sleep_out) begin
                    phase_n    = ph_init_wait;       // Step is held through the pause
                    timer_load = 1'b1;
                    timer_kind = tk_wait;
                end else if (step == init_step_last) begin
                    phase_n = ph_window;             // Straight into the full-screen clear
                    step_n  = '0;
                end else begin
                    step_n = step + 5'd1;
                end
            end

            ph_init_wait: begin
                timer_tick = 1'b1;
                if (timer_last) begin
                    phase_n = ph_init_cmd;
                    step_n  = step + 5'd1;
                end
            end

            ph_window: begin
                if (step == win_step_ramwr) begin
                    phase_n    = ph_pixels;
                    timer_load = 1'b1;
                    timer_kind = in_tile ? tk_tile : tk_clear;
                    hi_n       = 1'b0;               // Low byte goes first
                end else begin
                    step_n = step + 5'd1;
                end
            end

            ph_pixels: begin
                hi_n = !hi_byte;
                if (hi_byte) begin
                    // One pixel completes with its high byte
                    timer_tick    = 1'b1;
                    pixel_advance = 1'b1;
                    if (timer_last) begin
                        phase_n = ph_done;
                    end
                end
            end

            ph_done: begin
                phase_n = ph_idle;
            end

            default: begin
                phase_n = ph_idle;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== lcd_ctrl/lcd_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcd_timer
    import lcd_cmd_pkg::*;
#(
    parameter int tile_px     = 20,
    parameter int screen_w    = 240,
    parameter int screen_h    = 320,
    parameter int wait_cycles = 60000
) (
    input  logic        clk,
    input  logic        nrst,
    input  logic        load,
    input  timer_kind_t kind,
    input  logic        tick,
    output logic        last
);

    localparam int clear_len = screen_w * screen_h;
    localparam int tile_len  = tile_px * tile_px;
    localparam int big_len   = (clear_len > tile_len) ? clear_len : tile_len;
    localparam int max_len   = (wait_cycles > big_len) ? wait_cycles : big_len;
    localparam int cnt_w     = $clog2(max_len + 1);

    localparam logic [cnt_w-1:0] wait_last  = cnt_w'(wait_cycles - 1);
    localparam logic [cnt_w-1:0] clear_last = cnt_w'(clear_len - 1);
    localparam logic [cnt_w-1:0] tile_last  = cnt_w'(tile_len - 1);

    logic [cnt_w-1:0] count;
    logic [cnt_w-1:0] limit;
    timer_kind_t      kind_q;                        // Kind captured at load

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            count  <= '0;
            kind_q <= tk_wait;
        end else if (load) begin
            count  <= '0;
            kind_q <= kind;
        end else if (tick) begin
            count <= count + 1'b1;
        end
    end

    always_comb begin
        case (kind_q)
            tk_clear: limit = clear_last;
            tk_tile:  limit = tile_last;
            default:  limit = wait_last;
        endcase
    end

    assign last = (count == limit);

endmodule

`default_nettype wire

// ==== logic/tile_color.sv ====
`timescale 1ns/1ps
`default_nettype none

module tile_color
    import game_pkg::*;
(
    input  logic      clk,
    input  logic      nrst,
    input  obj_code_t obj,
    input  logic      fill_tile,
    input  logic      pixel_advance,
    output rgb565_t   color
);

    rgb565_t rainbow;
    rgb565_t palette;
    logic    feedback;

    assign feedback = ^(rainbow & rainbow_taps);

    // Runs on across tiles, only body pixels move it
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            rainbow <= rainbow_seed;
        end else if (pixel_advance && fill_tile && obj == obj_body) begin
            rainbow <= {rainbow[14:0], feedback};
        end
    end

    always_comb begin
        case (obj)
            obj_head:   palette = color_head;
            obj_body:   palette = rainbow;
            obj_apple:  palette = color_apple;
            obj_border: palette = color_border;
            default:    palette = color_background;  // Blank and unused codes
        endcase
    end

    // The clear after init paints background
    assign color = fill_tile ? palette : color_background;

endmodule

`default_nettype wire

// ==== logic/tile_painter_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tile_painter_top
    import lcd_cmd_pkg::*;
    import game_pkg::*;
#(
    parameter int tile_px     = 20,
    parameter int screen_w    = 240,
    parameter int screen_h    = 320,
    parameter int wait_cycles = 60000
) (
    input  logic      clk,
    input  logic      nrst,
    input  logic      start_init,
    input  logic      start_tile,
    input  tile_req_t tile,
    output lcd_bus_t  lcd,
    output logic      busy,
    output logic      done
);

    logic        accept;
    seq_phase_t  phase;
    logic [4:0]  step;
    logic        hi_byte;
    logic        timer_load;
    timer_kind_t timer_kind;
    logic        timer_tick;
    logic        timer_last;
    logic        pixel_advance;
    logic        fill_tile;
    logic        clear_q;                            // Full-screen window for the init clear
    tile_req_t   req_q;
    rgb565_t     color;

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            clear_q <= 1'b0;
        end else if (accept) begin
            clear_q <= start_init;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= tile;                           // Held steady for the whole draw
        end
    end

    lcd_seq_fsm u_seq (
        .clk           (clk),
        .nrst          (nrst),
        .start_init    (start_init),
        .start_tile    (start_tile),
        .timer_last    (timer_last),
        .accept        (accept),
        .phase         (phase),
        .step          (step),
        .hi_byte       (hi_byte),
        .timer_load    (timer_load),
        .timer_kind    (timer_kind),
        .timer_tick    (timer_tick),
        .pixel_advance (pixel_advance),
        .fill_tile     (fill_tile),
        .busy          (busy),
        .done          (done)
    );

    lcd_timer #(
        .tile_px     (tile_px),
        .screen_w    (screen_w),
        .screen_h    (screen_h),
        .wait_cycles (wait_cycles)
    ) u_timer (
        .clk  (clk),
        .nrst (nrst),
        .load (timer_load),
        .kind (timer_kind),
        .tick (timer_tick),
        .last (timer_last)
    );

    lcd_byte_gen #(
        .tile_px  (tile_px),
        .screen_w (screen_w),
        .screen_h (screen_h)
    ) u_byte_gen (
        .clk     (clk),
        .nrst    (nrst),
        .phase   (phase),
        .step    (step),
        .hi_byte (hi_byte),
        .clear   (clear_q),
        .tile    (req_q),
        .color   (color),
        .lcd     (lcd)
    );

    tile_color u_color (
        .clk           (clk),
        .nrst          (nrst),
        .obj           (req_q.obj),
        .fill_tile     (fill_tile),
        .pixel_advance (pixel_advance),
        .color         (color)
    );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Builds the tile painter testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tb_tile_painter -f files.f -o tb_tile_painter
out=$(./obj_dir/tb_tile_painter)
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx "test passed"; then
    exit 0
fi
echo "Simulation did not report a pass"
exit 1

// ==== testbench/tb_tile_painter.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_tile_painter
    import lcd_cmd_pkg::*;
    import game_pkg::*;
();

    localparam int tile_px     = 3;
    localparam int screen_w    = 4;
    localparam int screen_h    = 2;
    localparam int wait_cycles = 16;
    localparam int op_timeout  = 2000;               // Cycles allowed for one operation

    logic        clk;
    logic        nrst;
    logic        start_init;
    logic        start_tile;
    tile_req_t   tile;
    lcd_bus_t    lcd;
    logic        busy;
    logic        done;

    lcd_bus_t    got_q[$];                           // Every byte seen with wr high
    int          gap_q[$];                           // Cycles with wr low before each byte
    lcd_bus_t    exp_hdr[$];
    rgb565_t     exp_px[$];
    int          gap = 0;
    int          done_cnt = 0;
    int          mismatches;
    int          timeouts;
    int          other_errors;
    logic [31:0] rng;
    rgb565_t     model_rb;                           // Copy of the rainbow register

    tile_painter_top #(
        .tile_px     (tile_px),
        .screen_w    (screen_w),
        .screen_h    (screen_h),
        .wait_cycles (wait_cycles)
    ) DUT (
        .clk        (clk),
        .nrst       (nrst),
        .start_init (start_init),
        .start_tile (start_tile),
        .tile       (tile),
        .lcd        (lcd),
        .busy       (busy),
        .done       (done)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Bus monitor, samples half a cycle away from the DUT's clock edge
    always @(negedge clk) begin
        if (nrst) begin
            if (lcd.wr) begin
                got_q.push_back(lcd);
                gap_q.push_back(gap);
                gap = 0;
            end else begin
                gap = gap + 1;
            end
            if (done) begin
                done_cnt = done_cnt + 1;
            end
        end
    end

    // ########################################################################
    // Reference model
    // ########################################################################

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic rgb565_t rainbow_next(input rgb565_t r);
        return {r[14:0], r[15] ^ r[13] ^ r[12] ^ r[10]};
    endfunction

    function automatic rgb565_t palette_color(input int obj);
        case (obj)
            1:       return 16'h901E;                // Head
            3:       return 16'h00F8;                // Apple
            4:       return 16'h0000;                // Border
            default: return 16'h1408;                // Blank and unused codes
        endcase
    endfunction

    function automatic lcd_bus_t bus_byte(input logic dcx, input logic [7:0] data);
        lcd_bus_t b;
        b.wr   = 1'b1;
        b.dcx  = dcx;
        b.data = data;
        return b;
    endfunction

    task automatic add_coord(input int v);
        exp_hdr.push_back(bus_byte(1'b1, 8'(v >> 8)));   // High byte first
        exp_hdr.push_back(bus_byte(1'b1, 8'(v)));
    endtask

    task automatic add_window(input int c0, input int c1, input int p0, input int p1);
        exp_hdr.push_back(bus_byte(1'b0, 8'h2A));
        add_coord(c0);
        add_coord(c1);
        exp_hdr.push_back(bus_byte(1'b0, 8'h2B));
        add_coord(p0);
        add_coord(p1);
        exp_hdr.push_back(bus_byte(1'b0, 8'h2C));
    endtask

    task automatic build_model(input logic is_init, input int x, input int y, input int obj);
        int i;
        exp_hdr.delete();
        exp_px.delete();
        if (is_init) begin
            exp_hdr.push_back(bus_byte(1'b0, 8'h01));
            exp_hdr.push_back(bus_byte(1'b0, 8'h28));
            exp_hdr.push_back(bus_byte(1'b0, 8'h3A));
            exp_hdr.push_back(bus_byte(1'b1, 8'h55));
            exp_hdr.push_back(bus_byte(1'b0, 8'h11));
            exp_hdr.push_back(bus_byte(1'b0, 8'h29));
            add_window(0, screen_w - 1, 0, screen_h - 1);
            for (i = 0; i < screen_w * screen_h; i++) begin
                exp_px.push_back(16'h1408);
            end
        end else begin
            add_window(x * tile_px, x * tile_px + tile_px - 1,
                       y * tile_px, y * tile_px + tile_px - 1);
            for (i = 0; i < tile_px * tile_px; i++) begin
                if (obj == 2) begin
                    exp_px.push_back(model_rb);
                    model_rb = rainbow_next(model_rb);
                end else begin
                    exp_px.push_back(palette_color(obj));
                end
            end
        end
    endtask

    // ########################################################################
    // Compare tasks
    // ########################################################################

    task automatic check_bus(input string name, input lcd_bus_t got, input lcd_bus_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s got wr=%b dcx=%b data=%h, expected wr=%b dcx=%b data=%h",
                     $time, name, got.wr, got.dcx, got.data, exp.wr, exp.dcx, exp.data);
        end
    endtask

    task automatic check_color(input string name, input rgb565_t got, input rgb565_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s got %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s got %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic compare_stream(input logic is_init, input int exp_cnt);
        int       hdr;
        int       i;
        int       p;
        lcd_bus_t lo;
        lcd_bus_t hi;
        hdr = exp_hdr.size();
        check_count("model byte count", hdr + 2 * exp_px.size(), exp_cnt);
        check_count("byte count", got_q.size(), exp_cnt);
        for (i = 0; i < hdr && i < got_q.size(); i++) begin
            check_bus($sformatf("lcd byte %0d", i), got_q[i], exp_hdr[i]);
        end
        for (p = 0; p < exp_px.size() && hdr + 2 * p + 1 < got_q.size(); p++) begin
            lo = got_q[hdr + 2 * p];                 // Low byte goes out first
            hi = got_q[hdr + 2 * p + 1];
            if (!(lo.dcx && hi.dcx)) begin
                other_errors++;
                $display("Pixel %0d was sent with dcx low, as a command", p);
            end
            check_color($sformatf("pixel %0d", p), {hi.data, lo.data}, exp_px[p]);
        end
        // Only the two init pauses may leave wr low between bytes
        for (i = 1; i < gap_q.size(); i++) begin
            check_count($sformatf("wr low cycles before byte %0d", i), gap_q[i],
                        (is_init && (i == 1 || i == 5)) ? wait_cycles : 0);
        end
    endtask

    // ########################################################################
    // Operations
    // ########################################################################

    task automatic run_op(input logic is_init, input int x, input int y, input int obj,
                          input int exp_cnt);
        int   n;
        int   busy_at;
        int   wr_at;
        logic seen_busy;
        logic seen_done;
        logic finished;
        logic prev_wr;
        build_model(is_init, x, y, obj);
        got_q.delete();
        gap_q.delete();
        n         = 0;
        busy_at   = -1;
        wr_at     = -1;
        seen_busy = 1'b0;
        seen_done = 1'b0;
        finished  = 1'b0;
        prev_wr   = 1'b0;
        @(posedge clk);
        if (is_init) begin
            start_init <= 1'b1;
        end else begin
            start_tile <= 1'b1;
            tile       <= '{obj: obj_code_t'(obj[2:0]), x: x[3:0], y: y[3:0]};
        end
        while (!finished && n < op_timeout) begin
            @(posedge clk);
            start_init <= 1'b0;
            start_tile <= 1'b0;
            rng = xorshift(rng);
            // A stray start here is sampled while busy is still high
            if (seen_busy && !seen_done && rng[2:0] == 3'd0) begin
                start_init <= rng[3];
                start_tile <= !rng[3];
                tile       <= tile_req_t'(rng[26:16]);
            end
            @(negedge clk);
            seen_busy = busy;
            seen_done = done;
            if (busy && busy_at < 0) busy_at = n;
            if (busy_at >= 0) begin
                check_level("busy during operation", busy, 1'b1);
            end
            if (lcd.wr && wr_at < 0) wr_at = n;
            if (done) begin
                // Done follows the last byte by one cycle
                check_level("wr in the cycle before done", prev_wr, 1'b1);
                check_level("wr in the done cycle", lcd.wr, 1'b0);
            end
            prev_wr  = lcd.wr;
            finished = done;
            n++;
        end
        @(posedge clk);
        start_init <= 1'b0;
        start_tile <= 1'b0;
        if (!finished) begin
            timeouts++;
            $display("Timeout: no done pulse within %0d cycles of the start", op_timeout);
        end else begin
            check_count("cycles to busy", busy_at, 0);
            check_count("cycles to first byte", wr_at, 1);
            compare_stream(is_init, exp_cnt);
        end
    endtask

    initial begin
        int          fd;
        int          r;
        int          x;
        int          y;
        int          obj;
        int          cnt;
        int          ops;
        int          idle;
        int          done_before;
        string       line;
        logic [31:0] op_word;
        nrst         = 1'b0;
        start_init   = 1'b0;
        start_tile   = 1'b0;
        tile         = '0;
        mismatches   = 0;
        timeouts     = 0;
        other_errors = 0;
        ops          = 0;
        rng          = 32'h3839;
        model_rb     = 16'hACE1;
        repeat (2) @(posedge clk);
        nrst <= 1'b1;
        repeat (4) begin
            @(negedge clk);
            check_bus("lcd after reset", lcd, '0);
            check_level("busy after reset", busy, 1'b0);
            check_level("done after reset", done, 1'b0);
        end
        fd = $fopen("testbench/tile_painter_tests.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("Could not open the test file");
        end else begin
            while (!$feof(fd) && timeouts == 0) begin
                r = $fgets(line, fd);
                r = $sscanf(line, "%s %d %d %d %d", op_word, x, y, obj, cnt);
                if (r == 5) begin
                    done_before = done_cnt;
                    if (op_word == "init") begin
                        run_op(1'b1, 0, 0, 0, cnt);
                    end else if (op_word == "tile") begin
                        run_op(1'b0, x, y, obj, cnt);
                    end else begin
                        other_errors++;
                        $display("Unknown operation in the test file: %s", op_word);
                    end
                    ops++;
                    rng  = xorshift(rng);
                    idle = 1 + int'(rng[2:0]);
                    repeat (idle) @(posedge clk);
                    @(negedge clk);
                    check_level("busy between operations", busy, 1'b0);
                    check_level("done between operations", done, 1'b0);
                    check_count("done pulses", done_cnt - done_before, 1);
                end
            end
            $fclose(fd);
            if (ops == 0) begin
                other_errors++;
                $display("The test file held no operations");
            end
        end
        $display("Errors: %0d mismatches, %0d timeouts, %0d other", mismatches, timeouts,
                 other_errors);
        if (mismatches + timeouts + other_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/tile_painter_tests.txt ====
# Columns: op x y obj bytes, where op is init or tile and obj is the object code
# bytes is the number of writes with wr high that the operation must produce
init 0 0 0 33
tile 0 0 2 29
tile 1 0 2 29
tile 2 0 1 29
tile 3 0 2 29
tile 0 1 3 29
tile 1 1 2 29
tile 2 1 4 29
tile 3 1 0 29
tile 4 2 5 29
tile 5 2 6 29
tile 6 3 7 29
tile 7 3 2 29
tile 15 15 1 29
tile 15 0 2 29
tile 0 15 3 29
init 0 0 0 33
tile 9 4 2 29
tile 10 5 4 29
tile 11 6 2 29
tile 12 7 0 29
tile 13 8 2 29
